//--- Makefile
VERILATOR  ?= verilator
TOP        := bp_tb
FILELIST   := bp_unit.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bp_unit.f
design/bp_pkg.sv
design/bp_update_if.sv
design/bht.sv
design/btb.sv
design/branch_predictor.sv
design/bp_unit.sv
testbench/bp_tb.sv

//--- design/bht.sv
`timescale 1ns/1ps
`default_nettype none

module bht #(
	parameter int SIZE = 64
)(
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire bp_pkg::virt_t             vaddr,
	bp_update_if.sink                      update,
	output bp_pkg::bht_predict_t [1:0]     predict
);

	localparam int IDX_W = $clog2(SIZE);

	// one counter array per bank, bank is pc bit 2
	bp_pkg::counter_t cnt_mem [2][SIZE];

	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;
	logic             wr_bank;
	logic             wr_en;
	bp_pkg::counter_t cnt_next;

	assign rd_idx  = vaddr[IDX_W+2:3];
	assign wr_idx  = update.pc[IDX_W+2:3];
	assign wr_bank = update.pc[2];

	// only conditional branches carry a direction worth learning
	assign wr_en = update.valid && (update.cf == bp_pkg::cf_branch);

	// step the predicted counter toward the outcome, saturating at both ends
	always_comb begin
		cnt_next = update.counter;
		if (update.taken) begin
			if (update.counter != 2'b11) begin
				cnt_next = update.counter + 2'd1;
			end
		end else if (update.counter != 2'b00) begin
			cnt_next = update.counter - 2'd1;
		end
	end

	// read samples the old content when it hits the entry being trained
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < SIZE; i++) begin
					cnt_mem[b][i] <= bp_pkg::counter_reset;
				end
			end
			predict <= {2{bp_pkg::counter_reset}};
		end else begin
			predict[0] <= cnt_mem[0][rd_idx];
			predict[1] <= cnt_mem[1][rd_idx];
			if (wr_en) begin
				cnt_mem[wr_bank][wr_idx] <= cnt_next;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/bp_pkg.sv
`default_nettype none

package bp_pkg;

	// 32-bit virtual address, fetch pairs are 8-byte aligned
	typedef logic [31:0] virt_t;

	// control-flow kind of an instruction, cf_none marks a btb miss
	typedef enum logic [1:0] {
		cf_none     = 2'd0,
		cf_branch   = 2'd1,
		cf_jump     = 2'd2,
		cf_jump_reg = 2'd3
	} cf_t;

	// 2-bit saturating counter, bit 1 set means predicted taken
	typedef logic [1:0] counter_t;

	// counter read for one slot
	typedef counter_t bht_predict_t;

	// btb read for one slot
	typedef struct packed {
		cf_t   cf;
		virt_t target;
	} btb_predict_t;

	// weakly not taken
	localparam counter_t counter_reset = 2'b01;

endpackage

`default_nettype wire

//--- design/bp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bp_unit #(
	parameter int SIZE       = 64,
	parameter int LINE_BYTES = 32
)(
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              flush,

	// fetch side
	input  wire bp_pkg::virt_t     pc_cur,

	// training from execute, one event per cycle with upd_valid high
	input  wire logic              upd_valid,
	input  wire bp_pkg::virt_t     upd_pc,
	input  wire bp_pkg::virt_t     upd_target,
	input  wire bp_pkg::cf_t       upd_cf,
	input  wire logic              upd_taken,
	input  wire bp_pkg::counter_t  upd_counter,

	// prediction, one cycle after pc_cur
	output logic                   pred_valid,
	output logic                   pred_taken,
	output bp_pkg::virt_t          pred_target,
	output bp_pkg::cf_t            pred_cf,
	output bp_pkg::counter_t       pred_counter,
	output logic [1:0]             pred_sel
);

	bp_update_if upd ();

	assign upd.valid   = upd_valid;
	assign upd.pc      = upd_pc;
	assign upd.target  = upd_target;
	assign upd.cf      = upd_cf;
	assign upd.taken   = upd_taken;
	assign upd.counter = upd_counter;

	branch_predictor #(
		.SIZE       (SIZE),
		.LINE_BYTES (LINE_BYTES)
	) predictor_inst (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.pc_cur       (pc_cur),
		.update       (upd),
		.pred_valid   (pred_valid),
		.pred_taken   (pred_taken),
		.pred_target  (pred_target),
		.pred_cf      (pred_cf),
		.pred_counter (pred_counter),
		.pred_sel     (pred_sel)
	);

endmodule

`default_nettype wire

//--- design/bp_update_if.sv
`timescale 1ns/1ps
`default_nettype none

// one resolved control-flow instruction from execute, no back-pressure
interface bp_update_if;

	logic             valid;
	bp_pkg::virt_t    pc;
	bp_pkg::virt_t    target;
	bp_pkg::cf_t      cf;
	logic             taken;
	// counter that was predicted for this instruction
	bp_pkg::counter_t counter;

	modport src (
		output valid, pc, target, cf, taken, counter
	);

	modport sink (
		input valid, pc, target, cf, taken, counter
	);

endinterface

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
	parameter int SIZE       = 64,
	parameter int LINE_BYTES = 32
)(
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              flush,

	// fetch pair address, both slots are looked up
	input  wire bp_pkg::virt_t     pc_cur,

	// resolved branches from execute
	bp_update_if.sink              update,

	// prediction for the pc_cur of the previous cycle
	output logic                   pred_valid,
	output logic                   pred_taken,
	output bp_pkg::virt_t          pred_target,
	output bp_pkg::cf_t            pred_cf,
	output bp_pkg::counter_t       pred_counter,
	output logic [1:0]             pred_sel
);

	localparam int LINE_W = $clog2(LINE_BYTES);

	bp_pkg::bht_predict_t [1:0] bht_predict;
	bp_pkg::btb_predict_t [1:0] btb_predict;

	bp_pkg::virt_t        pc_prev;
	logic                 flush_q;
	logic                 slot;
	logic                 last_pair;
	bp_pkg::btb_predict_t btb_sel;
	bp_pkg::bht_predict_t bht_sel;

	// pc_prev lines up with the registered table outputs
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_prev <= '0;
			flush_q <= 1'b0;
		end else begin
			pc_prev <= pc_cur;
			flush_q <= flush;
		end
	end

	// an odd fetch address only has slot 1 in the pair
	always_comb begin
		if (pc_prev[2]) begin
			slot = 1'b1;
		end else begin
			slot = (btb_predict[0].cf == bp_pkg::cf_none);
		end
	end

	assign btb_sel = btb_predict[slot];
	assign bht_sel = bht_predict[slot];

	// last pair of a line leaves no room for the delay slot
	assign last_pair = &pc_prev[LINE_W-1:3];

	assign pred_sel     = slot ? 2'b10 : 2'b01;
	assign pred_target  = btb_sel.target;
	assign pred_cf      = btb_sel.cf;
	assign pred_counter = bht_sel;

	// jumps are always taken
	assign pred_taken = (btb_sel.cf == bp_pkg::cf_branch) ? bht_sel[1] : 1'b1;

	assign pred_valid = (btb_sel.cf != bp_pkg::cf_none) && !last_pair && !flush_q;

	bht #(
		.SIZE (SIZE)
	) bht_inst (
		.clk     (clk),
		.rst     (rst),
		.vaddr   ({pc_cur[31:3], 3'b000}),
		.update  (update),
		.predict (bht_predict)
	);

	btb #(
		.SIZE (SIZE)
	) btb_inst (
		.clk     (clk),
		.rst     (rst),
		.vaddr   ({pc_cur[31:3], 3'b000}),
		.update  (update),
		.predict (btb_predict)
	);

endmodule

`default_nettype wire

//--- design/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb #(
	parameter int SIZE = 64
)(
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire bp_pkg::virt_t             vaddr,
	bp_update_if.sink                      update,
	output bp_pkg::btb_predict_t [1:0]     predict
);

	localparam int IDX_W = $clog2(SIZE);
	localparam int TAG_W = 32 - IDX_W - 3;

	// per bank entry fields, only the valid bits are reset
	logic [1:0][SIZE-1:0] entry_valid;
	logic [TAG_W-1:0]     tag_mem [2][SIZE];
	bp_pkg::cf_t          cf_mem  [2][SIZE];
	bp_pkg::virt_t        tgt_mem [2][SIZE];

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;
	logic [TAG_W-1:0] wr_tag;
	logic             wr_bank;
	logic [1:0]       hit;

	bp_pkg::btb_predict_t [1:0] lookup;

	assign rd_idx  = vaddr[IDX_W+2:3];
	assign rd_tag  = vaddr[31:IDX_W+3];
	assign wr_idx  = update.pc[IDX_W+2:3];
	assign wr_tag  = update.pc[31:IDX_W+3];
	assign wr_bank = update.pc[2];

	// tag compare per bank, a miss reads as cf_none with a zero target
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			hit[b] = entry_valid[b][rd_idx] && (tag_mem[b][rd_idx] == rd_tag);
			if (hit[b]) begin
				lookup[b].cf     = cf_mem[b][rd_idx];
				lookup[b].target = tgt_mem[b][rd_idx];
			end else begin
				lookup[b].cf     = bp_pkg::cf_none;
				lookup[b].target = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= '0;
			for (int b = 0; b < 2; b++) begin
				predict[b].cf     <= bp_pkg::cf_none;
				predict[b].target <= '0;
			end
		end else begin
			predict <= lookup;
			// training with cf_none drops the entry
			if (update.valid) begin
				entry_valid[wr_bank][wr_idx] <= (update.cf != bp_pkg::cf_none);
			end
		end
	end

	// every resolved control-flow instruction overwrites its entry
	always_ff @(posedge clk) begin
		if (update.valid) begin
			tag_mem[wr_bank][wr_idx] <= wr_tag;
			cf_mem[wr_bank][wr_idx]  <= update.cf;
			tgt_mem[wr_bank][wr_idx] <= update.target;
		end
	end

endmodule

`default_nettype wire

//--- testbench/bp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bp_tb;

	localparam int SIZE            = 16;
	localparam int LINE_BYTES      = 32;
	localparam int IDX_W           = $clog2(SIZE);
	localparam int TAG_W           = 32 - IDX_W - 3;
	localparam int LINE_W          = $clog2(LINE_BYTES);
	localparam int RESET_CYCLES    = 10;
	localparam int DIRECTED_CYCLES = 200;
	localparam int RANDOM_CYCLES   = 2000;
	localparam int WATCHDOG_NS     = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 4 * 2;

	logic             clk = 1'b0;
	logic             rst;
	logic             flush;
	bp_pkg::virt_t    pc_cur;
	logic             upd_valid;
	bp_pkg::virt_t    upd_pc;
	bp_pkg::virt_t    upd_target;
	bp_pkg::cf_t      upd_cf;
	logic             upd_taken;
	bp_pkg::counter_t upd_counter;
	logic             pred_valid;
	logic             pred_taken;
	bp_pkg::virt_t    pred_target;
	bp_pkg::cf_t      pred_cf;
	bp_pkg::counter_t pred_counter;
	logic [1:0]       pred_sel;

	// reference tables with the bank taken from pc bit 2
	bp_pkg::counter_t m_cnt   [2][SIZE];
	logic             m_valid [2][SIZE];
	logic [TAG_W-1:0] m_tag   [2][SIZE];
	bp_pkg::cf_t      m_cf    [2][SIZE];
	bp_pkg::virt_t    m_tgt   [2][SIZE];

	// reads taken for the previous pc_cur
	bp_pkg::counter_t r_cnt [2];
	bp_pkg::cf_t      r_cf  [2];
	bp_pkg::virt_t    r_tgt [2];
	bp_pkg::virt_t    r_pc;
	logic             r_flush;

	logic             exp_slot;
	bp_pkg::cf_t      exp_cf;
	bp_pkg::counter_t exp_counter;

	bp_unit #(
		.SIZE       (SIZE),
		.LINE_BYTES (LINE_BYTES)
	) uut (.*);

	always #2 clk = ~clk;

	function automatic bp_pkg::counter_t next_counter(input bp_pkg::counter_t c, input logic taken);
		if (taken) begin
			return (c == 2'b11) ? c : c + 2'd1;
		end
		return (c == 2'b00) ? c : c - 2'd1;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < SIZE; i++) begin
					m_cnt[b][i]   <= bp_pkg::counter_reset;
					m_valid[b][i] <= 1'b0;
				end
				r_cnt[b] <= bp_pkg::counter_reset;
				r_cf[b]  <= bp_pkg::cf_none;
				r_tgt[b] <= '0;
			end
			r_pc    <= '0;
			r_flush <= 1'b0;
		end else begin
			// reads see the tables as they were before this edge's training
			for (int b = 0; b < 2; b++) begin
				r_cnt[b] <= m_cnt[b][pc_cur[IDX_W+2:3]];
				if (m_valid[b][pc_cur[IDX_W+2:3]]
						&& m_tag[b][pc_cur[IDX_W+2:3]] == pc_cur[31:IDX_W+3]) begin
					r_cf[b]  <= m_cf[b][pc_cur[IDX_W+2:3]];
					r_tgt[b] <= m_tgt[b][pc_cur[IDX_W+2:3]];
				end else begin
					r_cf[b]  <= bp_pkg::cf_none;
					r_tgt[b] <= '0;
				end
			end
			r_pc    <= pc_cur;
			r_flush <= flush;
			if (upd_valid) begin
				m_valid[upd_pc[2]][upd_pc[IDX_W+2:3]] <= (upd_cf != bp_pkg::cf_none);
				m_tag[upd_pc[2]][upd_pc[IDX_W+2:3]]   <= upd_pc[31:IDX_W+3];
				m_cf[upd_pc[2]][upd_pc[IDX_W+2:3]]    <= upd_cf;
				m_tgt[upd_pc[2]][upd_pc[IDX_W+2:3]]   <= upd_target;
				if (upd_cf == bp_pkg::cf_branch) begin
					m_cnt[upd_pc[2]][upd_pc[IDX_W+2:3]] <= next_counter(upd_counter, upd_taken);
				end
			end
		end
	end

	assign exp_slot    = r_pc[2] ? 1'b1 : (r_cf[0] == bp_pkg::cf_none);
	assign exp_cf      = r_cf[exp_slot];
	assign exp_counter = r_cnt[exp_slot];

	task automatic report_mismatch(input string field);
		$display("Mismatch at %0t ns: %s differs from the reference model", $time, field);
		$display("sim failed");
		$fatal(1, "prediction check failed");
	endtask

	assert property (@(posedge clk) disable iff (rst) pred_valid == ((exp_cf != bp_pkg::cf_none)
			&& !(&r_pc[LINE_W-1:3]) && !r_flush))
		else report_mismatch("pred_valid");
	assert property (@(posedge clk) disable iff (rst)
			pred_taken == ((exp_cf == bp_pkg::cf_branch) ? exp_counter[1] : 1'b1))
		else report_mismatch("pred_taken");
	assert property (@(posedge clk) disable iff (rst) pred_target == r_tgt[exp_slot])
		else report_mismatch("pred_target");
	assert property (@(posedge clk) disable iff (rst) pred_cf == exp_cf)
		else report_mismatch("pred_cf");
	assert property (@(posedge clk) disable iff (rst) pred_counter == exp_counter)
		else report_mismatch("pred_counter");
	assert property (@(posedge clk) disable iff (rst) pred_sel == (exp_slot ? 2'b10 : 2'b01))
		else report_mismatch("pred_sel");

	task automatic fetch(input bp_pkg::virt_t pc);
		pc_cur = pc;
		@(negedge clk);
	endtask

	// one training strobe that leaves pc_cur as it was
	task automatic train(input bp_pkg::virt_t pc, input bp_pkg::virt_t target,
			input bp_pkg::cf_t cf, input logic taken, input bp_pkg::counter_t cnt);
		upd_valid   = 1'b1;
		upd_pc      = pc;
		upd_target  = target;
		upd_cf      = cf;
		upd_taken   = taken;
		upd_counter = cnt;
		@(negedge clk);
		upd_valid = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		bp_pkg::counter_t cnt;
		int unsigned      r;
		void'($urandom(32'hf9c26747));
		rst         = 1'b1;
		flush       = 1'b0;
		pc_cur      = '0;
		upd_valid   = 1'b0;
		upd_pc      = '0;
		upd_target  = '0;
		upd_cf      = bp_pkg::cf_none;
		upd_taken   = 1'b0;
		upd_counter = bp_pkg::counter_reset;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		// untrained tables miss in both banks
		fetch(32'h0);
		fetch(32'h4);
		fetch(32'h18);
		fetch(32'h104);
		// bank 0 hit wins over bank 1 and pc bit 2 forces slot 1
		train(32'h40, 32'h1000, bp_pkg::cf_jump, 1'b1, 2'b00);
		fetch(32'h40);
		fetch(32'h44);
		train(32'h4c, 32'h2000, bp_pkg::cf_jump_reg, 1'b1, 2'b00);
		fetch(32'h48);
		train(32'h48, 32'h3000, bp_pkg::cf_jump, 1'b1, 2'b00);
		fetch(32'h48);
		fetch(32'h4c);
		// counter fed back from the prediction climbs to 11 and then falls to 00
		for (int i = 0; i < 10; i++) begin
			fetch(32'h50);
			cnt = pred_counter;
			train(32'h50, 32'h800, bp_pkg::cf_branch, i < 4, cnt);
		end
		fetch(32'h50);
		// last pair of a line and the cycle after flush
		train(32'h58, 32'h4000, bp_pkg::cf_jump, 1'b1, 2'b00);
		fetch(32'h58);
		flush = 1'b1;
		fetch(32'h40);
		flush = 1'b0;
		fetch(32'h40);
		// same index with another tag and then removal by cf_none
		fetch(32'hc0);
		train(32'h40, 32'h0, bp_pkg::cf_none, 1'b0, 2'b00);
		fetch(32'h40);
		// training and reading one entry at the same edge
		fetch(32'h48);
		train(32'h48, 32'h5000, bp_pkg::cf_jump, 1'b1, 2'b00);
		fetch(32'h48);
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			r           = $urandom;
			pc_cur      = {23'd0, r[8:2], 2'b00};
			flush       = (r[12:9] == 4'd0);
			upd_valid   = r[13];
			upd_taken   = r[14];
			upd_counter = r[16:15];
			upd_cf      = bp_pkg::cf_t'(r[18:17]);
			upd_pc      = {23'd0, r[27:21], 2'b00};
			upd_target  = $urandom;
			@(negedge clk);
		end
		flush     = 1'b0;
		upd_valid = 1'b0;
		fetch(32'h0);
		fetch(32'h0);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
